// File: verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths
`define ADDR_LEN 32
`define DATA_LEN 32
`define INSN_LEN 32

// architectural register index
`define REG_SEL 5

// one rename slot per rob entry
`define RRF_NUM 8
`define RRF_SEL 3

// alu reservation station
`define RS_ENT_NUM 4

// first fetch address out of reset
`define ENTRY_POINT 32'h0000_0000

`endif

// File: verilog/decode_pkg.sv
`include "core_params.svh"

package decode_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // one instruction out of the decode register
    typedef struct packed {
        logic                 valid;
        logic                 illegal;
        logic [`REG_SEL-1:0]  rs1;
        logic [`REG_SEL-1:0]  rs2;
        logic [`REG_SEL-1:0]  rd;
        logic                 wr_reg;
        logic                 uses_imm;
        logic [`DATA_LEN-1:0] imm;
        alu_op_e              alu_op;
    } decoded_t;

endpackage

// File: verilog/ooo_pkg.sv
`include "core_params.svh"

package ooo_pkg;

    typedef logic [`RRF_SEL-1:0] rrf_tag_t;

    // val carries the tag in its low bits while not ready
    typedef struct packed {
        logic                 ready;
        logic [`DATA_LEN-1:0] val;
    } operand_t;

    typedef struct packed {
        operand_t            src1;
        operand_t            src2;
        decode_pkg::alu_op_e alu_op;
        rrf_tag_t            dst_tag;
    } rs_entry_t;

    typedef struct packed {
        logic                 valid;
        rrf_tag_t             tag;
        logic [`DATA_LEN-1:0] data;
    } result_t;

    typedef struct packed {
        logic                valid;
        rrf_tag_t            tag;
        logic [`REG_SEL-1:0] rd;
        logic                dst_valid;
    } rob_head_t;

    typedef struct packed {
        logic                 valid;
        logic [`REG_SEL-1:0]  rd;
        logic [`DATA_LEN-1:0] data;
    } commit_t;

endpackage

// File: verilog/fetch_decode.sv
`timescale 1ns/10ps
`include "core_params.svh"

module fetch_decode (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic [`INSN_LEN-1:0]  idata_i,
    output logic [`ADDR_LEN-1:0]  iaddr_o,
    output decode_pkg::decoded_t  dec_o
);

    logic [`ADDR_LEN-1:0] pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic is_op;
    logic is_imm;
    logic f7_zero;
    logic f7_alt;
    logic f7_ok;
    logic illegal;
    decode_pkg::alu_op_e alu_op;
    decode_pkg::decoded_t dec;

    assign iaddr_o = pc;
    assign opcode  = idata_i[6:0];
    assign funct3  = idata_i[14:12];
    assign funct7  = idata_i[31:25];
    assign is_op   = opcode == 7'b0110011;
    assign is_imm  = opcode == 7'b0010011;
    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;

    // funct7 only matters for register forms and immediate shifts
    always_comb begin
        alu_op = decode_pkg::ALU_ADD;
        f7_ok  = is_imm || f7_zero;
        case (funct3)
            3'b000: begin
                alu_op = (is_op && f7_alt) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
                f7_ok  = is_imm || f7_zero || f7_alt;
            end
            3'b001: begin
                alu_op = decode_pkg::ALU_SLL;
                f7_ok  = f7_zero;
            end
            3'b010: alu_op = decode_pkg::ALU_SLT;
            3'b011: alu_op = decode_pkg::ALU_SLTU;
            3'b100: alu_op = decode_pkg::ALU_XOR;
            3'b101: begin
                alu_op = f7_alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                f7_ok  = f7_zero || f7_alt;
            end
            3'b110: alu_op = decode_pkg::ALU_OR;
            default: alu_op = decode_pkg::ALU_AND;
        endcase
    end

    assign illegal = !((is_op || is_imm) && f7_ok);

    assign dec = '{
        valid:    1'b1,
        illegal:  illegal,
        rs1:      idata_i[19:15],
        rs2:      idata_i[24:20],
        rd:       idata_i[11:7],
        wr_reg:   !illegal && (idata_i[11:7] != '0),
        uses_imm: is_imm,
        imm:      {{(`DATA_LEN-12){idata_i[31]}}, idata_i[31:20]},
        alu_op:   alu_op
    };

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc          <= `ENTRY_POINT;
            dec_o.valid <= 1'b0;
        end else if (!stall_i) begin
            pc    <= pc + `ADDR_LEN'(4);
            dec_o <= dec;
        end
    end

endmodule

// File: verilog/dispatch_ctrl.sv
`timescale 1ns/10ps

module dispatch_ctrl (
    input  decode_pkg::decoded_t dec_i,
    input  logic                 rob_full_i,
    input  logic                 rs_full_i,
    output logic                 dispatch_o,
    output logic                 stall_o
);

    logic legal;
    logic full;

    assign legal = dec_i.valid && !dec_i.illegal;

    // rob slot and station entry are both needed
    assign full = rob_full_i || rs_full_i;

    // illegal words fall through with neither
    assign dispatch_o = legal && !full;
    assign stall_o    = legal && full;

endmodule

// File: verilog/rename_unit.sv
`timescale 1ns/10ps
`include "core_params.svh"

module rename_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  dispatch_i,
    input  decode_pkg::decoded_t  dec_i,
    input  ooo_pkg::rrf_tag_t     alloc_tag_i,
    input  ooo_pkg::result_t      result_i,
    input  ooo_pkg::rob_head_t    head_i,
    output ooo_pkg::rs_entry_t    entry_o,
    output ooo_pkg::commit_t      commit_o
);

    localparam int reg_num = 2 ** `REG_SEL;

    logic [`DATA_LEN-1:0] arf [reg_num];
    logic [reg_num-1:0] busy;
    ooo_pkg::rrf_tag_t tag_map [reg_num];
    logic [`DATA_LEN-1:0] rrf_data [`RRF_NUM];
    logic [`RRF_NUM-1:0] rrf_valid;
    logic arf_we;

    // x0, then forwarded result, then arf, then rename file, else wait on tag
    function automatic ooo_pkg::operand_t lookup(input logic [`REG_SEL-1:0] idx);
        ooo_pkg::operand_t op;
        ooo_pkg::rrf_tag_t tag;
        tag      = tag_map[idx];
        op.ready = 1'b1;
        op.val   = arf[idx];
        if (idx == '0) begin
            op.val = '0;
        end else if (busy[idx]) begin
            if (result_i.valid && result_i.tag == tag) begin
                op.val = result_i.data;
            end else if (rrf_valid[tag]) begin
                op.val = rrf_data[tag];
            end else begin
                op.ready = 1'b0;
                op.val   = `DATA_LEN'(tag);
            end
        end
        return op;
    endfunction

    always_comb begin
        entry_o.src1    = lookup(dec_i.rs1);
        entry_o.src2    = dec_i.uses_imm ? {1'b1, dec_i.imm} : lookup(dec_i.rs2);
        entry_o.alu_op  = dec_i.alu_op;
        entry_o.dst_tag = alloc_tag_i;
    end

    assign arf_we   = head_i.valid && head_i.dst_valid;
    assign commit_o = '{valid: arf_we, rd: head_i.rd, data: rrf_data[head_i.tag]};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy      <= '0;
            rrf_valid <= '0;
            for (int i = 0; i < reg_num; i++) begin
                arf[i] <= '0;
            end
        end else begin
            if (result_i.valid) begin
                rrf_valid[result_i.tag] <= 1'b1;
            end
            if (arf_we) begin
                arf[head_i.rd] <= rrf_data[head_i.tag];
                // a younger writer may already own the mapping
                if (tag_map[head_i.rd] == head_i.tag) begin
                    busy[head_i.rd] <= 1'b0;
                end
            end
            if (dispatch_i) begin
                rrf_valid[alloc_tag_i] <= 1'b0;
                if (dec_i.wr_reg) begin
                    busy[dec_i.rd] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_i.valid) begin
            rrf_data[result_i.tag] <= result_i.data;
        end
        if (dispatch_i && dec_i.wr_reg) begin
            tag_map[dec_i.rd] <= alloc_tag_i;
        end
    end

    x0_never_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !busy[0]
    ) else $error("x0 marked busy");

endmodule

// File: verilog/alu_station.sv
`timescale 1ns/10ps
`include "core_params.svh"

module alu_station (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                dispatch_i,
    input  ooo_pkg::rs_entry_t  entry_i,
    output logic                rs_full_o,
    output ooo_pkg::result_t    result_o
);

    localparam int sel_w = $clog2(`RS_ENT_NUM);

    // slot 0 holds the oldest entry and the queue collapses on issue
    logic [`RS_ENT_NUM-1:0] vld;
    logic [`RS_ENT_NUM-1:0] nxt_vld;
    ooo_pkg::rs_entry_t ent [`RS_ENT_NUM];
    ooo_pkg::rs_entry_t woke [`RS_ENT_NUM];
    ooo_pkg::rs_entry_t nxt_ent [`RS_ENT_NUM];
    logic issue;
    logic [sel_w-1:0] sel;
    logic [`DATA_LEN-1:0] op_a;
    logic [`DATA_LEN-1:0] op_b;
    logic [`DATA_LEN-1:0] alu_out;
    logic res_valid;
    ooo_pkg::rrf_tag_t res_tag;
    logic [`DATA_LEN-1:0] res_data;

    function automatic ooo_pkg::operand_t wake(input ooo_pkg::operand_t op);
        ooo_pkg::operand_t o;
        o = op;
        if (!op.ready && result_o.valid && op.val[`RRF_SEL-1:0] == result_o.tag) begin
            o.ready = 1'b1;
            o.val   = result_o.data;
        end
        return o;
    endfunction

    // wakeup and oldest-ready select
    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = `RS_ENT_NUM - 1; i >= 0; i--) begin
            woke[i]      = ent[i];
            woke[i].src1 = wake(ent[i].src1);
            woke[i].src2 = wake(ent[i].src2);
            if (vld[i] && woke[i].src1.ready && woke[i].src2.ready) begin
                issue = 1'b1;
                sel   = sel_w'(i);
            end
        end
    end

    always_comb begin
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < `RS_ENT_NUM - 1; i++) begin
            nxt_vld[i] = (issue && sel_w'(i) >= sel) ? vld[i+1] : vld[i];
            nxt_ent[i] = (issue && sel_w'(i) >= sel) ? woke[i+1] : woke[i];
        end
        nxt_vld[`RS_ENT_NUM-1] = vld[`RS_ENT_NUM-1] && !issue;
        nxt_ent[`RS_ENT_NUM-1] = woke[`RS_ENT_NUM-1];
        for (int i = 0; i < `RS_ENT_NUM; i++) begin
            if (dispatch_i && !placed && !nxt_vld[i]) begin
                nxt_vld[i] = 1'b1;
                nxt_ent[i] = entry_i;
                placed     = 1'b1;
            end
        end
    end

    assign rs_full_o = &vld;

    assign op_a = woke[sel].src1.val;
    assign op_b = woke[sel].src2.val;

    always_comb begin
        case (woke[sel].alu_op)
            decode_pkg::ALU_ADD:  alu_out = op_a + op_b;
            decode_pkg::ALU_SUB:  alu_out = op_a - op_b;
            decode_pkg::ALU_AND:  alu_out = op_a & op_b;
            decode_pkg::ALU_OR:   alu_out = op_a | op_b;
            decode_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            decode_pkg::ALU_SLT:  alu_out = `DATA_LEN'($signed(op_a) < $signed(op_b));
            decode_pkg::ALU_SLTU: alu_out = `DATA_LEN'(op_a < op_b);
            decode_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
            decode_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
            decode_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            default:              alu_out = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld       <= '0;
            res_valid <= 1'b0;
        end else begin
            vld       <= nxt_vld;
            res_valid <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        ent      <= nxt_ent;
        res_tag  <= woke[sel].dst_tag;
        res_data <= alu_out;
    end

    assign result_o = '{valid: res_valid, tag: res_tag, data: res_data};

    no_dispatch_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) dispatch_i |-> !rs_full_o
    ) else $error("dispatch into a full station");

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/10ps
`include "core_params.svh"

module reorder_buffer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 dispatch_i,
    input  logic [`REG_SEL-1:0]  rd_i,
    input  logic                 dst_valid_i,
    input  ooo_pkg::result_t     result_i,
    output ooo_pkg::rrf_tag_t    alloc_tag_o,
    output logic                 rob_full_o,
    output ooo_pkg::rob_head_t   head_o
);

    // msb is the wrap bit
    logic [`RRF_SEL:0] head_ptr;
    logic [`RRF_SEL:0] tail_ptr;
    logic [`RRF_NUM-1:0] complete;
    logic [`RRF_NUM-1:0] dst_valid;
    logic [`REG_SEL-1:0] dst_rd [`RRF_NUM];
    ooo_pkg::rrf_tag_t head_tag;
    logic empty;
    logic retire;

    assign head_tag    = head_ptr[`RRF_SEL-1:0];
    assign alloc_tag_o = tail_ptr[`RRF_SEL-1:0];
    assign empty       = head_ptr == tail_ptr;
    assign rob_full_o  = (head_ptr[`RRF_SEL] != tail_ptr[`RRF_SEL]) &&
                         (head_tag == alloc_tag_o);
    assign retire      = !empty && complete[head_tag];

    assign head_o = '{
        valid:     retire,
        tag:       head_tag,
        rd:        dst_rd[head_tag],
        dst_valid: dst_valid[head_tag]
    };

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            complete <= '0;
        end else begin
            if (dispatch_i) begin
                complete[alloc_tag_o] <= 1'b0;
                tail_ptr              <= tail_ptr + (`RRF_SEL + 1)'(1);
            end
            if (result_i.valid) begin
                complete[result_i.tag] <= 1'b1;
            end
            if (retire) begin
                head_ptr <= head_ptr + (`RRF_SEL + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            dst_rd[alloc_tag_o]    <= rd_i;
            dst_valid[alloc_tag_o] <= dst_valid_i;
        end
    end

    no_dispatch_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) dispatch_i |-> !rob_full_o
    ) else $error("dispatch into a full reorder buffer");

endmodule

// File: verilog/helios_core.sv
`timescale 1ns/10ps
`include "core_params.svh"

module helios_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    output logic [`ADDR_LEN-1:0] iaddr_o,
    input  logic [`INSN_LEN-1:0] idata_i,
    output ooo_pkg::commit_t     commit_o
);

    decode_pkg::decoded_t dec;
    logic stall;
    logic dispatch;
    logic rob_full;
    logic rs_full;
    ooo_pkg::rrf_tag_t alloc_tag;
    ooo_pkg::rs_entry_t entry;
    ooo_pkg::result_t result;
    ooo_pkg::rob_head_t head;

    fetch_decode u_fetch_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall),
        .idata_i (idata_i),
        .iaddr_o (iaddr_o),
        .dec_o   (dec)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .dec_i      (dec),
        .rob_full_i (rob_full),
        .rs_full_i  (rs_full),
        .dispatch_o (dispatch),
        .stall_o    (stall)
    );

    rename_unit u_rename_unit (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dispatch_i  (dispatch),
        .dec_i       (dec),
        .alloc_tag_i (alloc_tag),
        .result_i    (result),
        .head_i      (head),
        .entry_o     (entry),
        .commit_o    (commit_o)
    );

    alu_station u_alu_station (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dispatch_i (dispatch),
        .entry_i    (entry),
        .rs_full_o  (rs_full),
        .result_o   (result)
    );

    reorder_buffer u_reorder_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dispatch_i  (dispatch),
        .rd_i        (dec.rd),
        .dst_valid_i (dec.wr_reg),
        .result_i    (result),
        .alloc_tag_o (alloc_tag),
        .rob_full_o  (rob_full),
        .head_o      (head)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns  = 20,
    parameter int rst_cycles = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (rst_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_helios_core.sv
`timescale 1ns/10ps
`include "core_params.svh"

module tb_helios_core;

    localparam int clk_period_ns = 20;
    localparam int n_indep       = 12;
    localparam int n_chain       = 40;
    localparam int total_insns   = 2 + n_indep + 10 + 8 + 10 + n_chain;
    localparam int watchdog_ns   = total_insns * 200 * clk_period_ns;
    localparam logic [`INSN_LEN-1:0] nop_word = 32'h0000_0013;

    logic clk;
    logic por_n;
    logic test_rst_n;
    logic rst_n;
    logic [`ADDR_LEN-1:0] iaddr;
    logic [`INSN_LEN-1:0] idata;
    ooo_pkg::commit_t commit;

    logic [`INSN_LEN-1:0] prog_q [$];
    ooo_pkg::commit_t expected_q [$];
    logic [`ADDR_LEN-1:0] last_addr;

    tb_clock #(.period_ns(clk_period_ns), .rst_cycles(3)) i_tb_clock (
        .clk_o   (clk),
        .rst_n_o (por_n)
    );

    assign rst_n = por_n && test_rst_n;

    helios_core i_helios_core (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .iaddr_o  (iaddr),
        .idata_i  (idata),
        .commit_o (commit)
    );

    // instruction memory returning nops past the end of the program
    initial begin
        int idx;
        idata = nop_word;
        forever begin
            @(negedge clk);
            idx = int'(iaddr >> 2);
            idata = (idx < prog_q.size()) ? prog_q[idx] : nop_word;
        end
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the DUT did not finish its retirements within %0d ns", watchdog_ns);
        abort_run();
    end

    task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: retired x%0d = %h, expected x%0d = %h",
                     $time, got.rd, got.data, exp.rd, exp.data);
            abort_run();
        end
    endtask

    task automatic check_addr(input logic [`ADDR_LEN-1:0] got,
                              input logic [`ADDR_LEN-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // fetch holds or moves on by one word
    task automatic next_cycle();
        @(negedge clk);
        if (iaddr !== last_addr) begin
            check_addr(iaddr, last_addr + `ADDR_LEN'(4), "fetch address step");
        end
        last_addr = iaddr;
    endtask

    function automatic logic [`INSN_LEN-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                    input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [`INSN_LEN-1:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                                    input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // RV32I OP and OP-IMM only
    function automatic logic legal_word(input logic [`INSN_LEN-1:0] w);
        if (w[6:0] == 7'h33) begin
            return w[31:25] == 7'h00 ||
                   (w[31:25] == 7'h20 && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
        end
        if (w[6:0] == 7'h13) begin
            if (w[14:12] == 3'b001) return w[31:25] == 7'h00;
            if (w[14:12] == 3'b101) return w[31:25] == 7'h00 || w[31:25] == 7'h20;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [`DATA_LEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                       input logic [`DATA_LEN-1:0] a,
                                                       input logic [`DATA_LEN-1:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {{(`DATA_LEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b011: return {{(`DATA_LEN-1){1'b0}}, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // in-order reference execution from a zeroed register file
    task automatic golden_model();
        logic [`DATA_LEN-1:0] regs [32];
        logic [`INSN_LEN-1:0] w;
        logic [`DATA_LEN-1:0] b;
        logic [`DATA_LEN-1:0] v;
        logic alt;
        foreach (regs[i]) regs[i] = '0;
        expected_q.delete();
        foreach (prog_q[i]) begin
            w = prog_q[i];
            if (legal_word(w)) begin
                b   = (w[6:0] == 7'h13) ? {{(`DATA_LEN-12){w[31]}}, w[31:20]} : regs[w[24:20]];
                alt = w[30] && (w[6:0] == 7'h33 || w[14:12] == 3'b101);
                v   = alu_model(w[14:12], alt, regs[w[19:15]], b);
                if (w[11:7] != 5'd0) begin
                    regs[w[11:7]] = v;
                    expected_q.push_back(ooo_pkg::commit_t'{valid: 1'b1, rd: w[11:7], data: v});
                end
            end
        end
    endtask

    task automatic run_program(input string name);
        $display("running %s, %0d instructions", name, prog_q.size());
        @(negedge clk);
        test_rst_n = 1'b0;
        golden_model();
        repeat (3) @(negedge clk);
        test_rst_n = 1'b1;
        last_addr = `ENTRY_POINT;
        check_addr(iaddr, `ENTRY_POINT, "fetch address after reset");
        repeat (3) begin
            if (commit.valid) begin
                $display("Retirement seen at %0t before any instruction could complete", $time);
                abort_run();
            end
            next_cycle();
        end
        foreach (expected_q[i]) begin
            while (!commit.valid) next_cycle();
            check_commit(commit, expected_q[i]);
            next_cycle();
        end
        repeat (16) begin
            if (commit.valid) begin
                $display("Unexpected extra retirement of x%0d at %0t", commit.rd, $time);
                abort_run();
            end
            next_cycle();
        end
    endtask

    task automatic test_reset_state();
        prog_q.delete();
        prog_q.push_back(i_type(3'b000, 5'd1, 5'd0, 12'h123));
        prog_q.push_back(i_type(3'b000, 5'd2, 5'd1, 12'hfff));
        run_program("reset state");
    endtask

    task automatic test_independent_imm();
        logic [2:0] f3;
        prog_q.delete();
        repeat (n_indep) begin
            case ($urandom_range(2, 0))
                0: f3 = 3'b000;
                1: f3 = 3'b100;
                default: f3 = 3'b110;
            endcase
            prog_q.push_back(i_type(f3, 5'($urandom_range(31, 1)), 5'($urandom_range(31, 0)),
                                    12'($urandom())));
        end
        run_program("independent immediates");
    endtask

    task automatic test_dependent_chain();
        prog_q.delete();
        prog_q.push_back(i_type(3'b000, 5'd1, 5'd0, 12'($urandom())));
        prog_q.push_back(i_type(3'b000, 5'd2, 5'd0, 12'($urandom())));
        prog_q.push_back(i_type(3'b000, 5'd3, 5'd0, 12'($urandom_range(31, 0))));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
        prog_q.push_back(r_type(7'h20, 3'b000, 5'd5, 5'd4, 5'd1));
        prog_q.push_back(r_type(7'h00, 3'b010, 5'd6, 5'd5, 5'd4));
        prog_q.push_back(r_type(7'h00, 3'b001, 5'd7, 5'd4, 5'd3));
        prog_q.push_back(r_type(7'h20, 3'b101, 5'd8, 5'd7, 5'd3));
        // x4 renamed a second time while older readers may still wait
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd4, 5'd8, 5'd6));
        prog_q.push_back(r_type(7'h20, 3'b000, 5'd9, 5'd4, 5'd4));
        run_program("dependent chain");
    endtask

    task automatic test_x0_writes();
        prog_q.delete();
        prog_q.push_back(i_type(3'b000, 5'd1, 5'd0, 12'($urandom())));
        prog_q.push_back(i_type(3'b000, 5'd0, 5'd1, 12'($urandom())));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        prog_q.push_back(i_type(3'b100, 5'd0, 5'd1, 12'hfff));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
        prog_q.push_back(r_type(7'h20, 3'b000, 5'd3, 5'd0, 5'd1));
        prog_q.push_back(i_type(3'b110, 5'd4, 5'd0, 12'($urandom())));
        prog_q.push_back(r_type(7'h00, 3'b011, 5'd5, 5'd0, 5'd1));
        run_program("x0 writes");
    endtask

    task automatic test_illegal_mix();
        prog_q.delete();
        prog_q.push_back(i_type(3'b000, 5'd1, 5'd0, 12'($urandom())));
        prog_q.push_back(32'h0000_2103);
        prog_q.push_back(i_type(3'b000, 5'd2, 5'd1, 12'($urandom())));
        prog_q.push_back(r_type(7'h01, 3'b000, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        prog_q.push_back(i_type(3'b001, 5'd4, 5'd1, 12'h405));
        prog_q.push_back(r_type(7'h20, 3'b111, 5'd5, 5'd1, 5'd2));
        prog_q.push_back(r_type(7'h00, 3'b100, 5'd5, 5'd3, 5'd2));
        prog_q.push_back(32'h0011_2023);
        prog_q.push_back(r_type(7'h00, 3'b111, 5'd6, 5'd5, 5'd1));
        run_program("illegal encodings");
    endtask

    task automatic test_long_chain();
        logic [4:0] prev;
        logic [4:0] rd;
        prog_q.delete();
        prog_q.push_back(i_type(3'b000, 5'd1, 5'd0, 12'($urandom())));
        prog_q.push_back(i_type(3'b000, 5'd2, 5'd0, 12'($urandom())));
        prev = 5'd1;
        repeat (n_chain - 2) begin
            rd = 5'($urandom_range(31, 3));
            case ($urandom_range(5, 0))
                0: prog_q.push_back(r_type(7'h00, 3'b000, rd, prev, 5'd2));
                1: prog_q.push_back(r_type(7'h20, 3'b000, rd, prev, 5'd2));
                2: prog_q.push_back(r_type(7'h00, 3'b100, rd, prev, 5'd2));
                3: prog_q.push_back(r_type(7'h20, 3'b101, rd, prev, 5'd2));
                4: prog_q.push_back(r_type(7'h00, 3'b011, rd, prev, 5'd2));
                default: prog_q.push_back(i_type(3'b110, rd, prev, 12'($urandom())));
            endcase
            prev = rd;
        end
        run_program("long dependency chain");
    endtask

    initial begin
        test_rst_n = 1'b0;
        last_addr  = `ENTRY_POINT;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h6728_3883));
        test_reset_state();
        test_independent_imm();
        test_dependent_chain();
        test_x0_writes();
        test_illegal_mix();
        test_long_chain();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/ooo_pkg.sv
verilog/fetch_decode.sv
verilog/dispatch_ctrl.sv
verilog/rename_unit.sv
verilog/alu_station.sv
verilog/reorder_buffer.sv
verilog/helios_core.sv
tests/tb_clock.sv
tests/tb_helios_core.sv

// File: Makefile
TOP = tb_helios_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
